// File: hdl/mq_cfg_pkg.sv
`default_nettype none

package mq_cfg_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Queue geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int NUM_QUEUES  = 4;
    localparam int QUEUE_DEPTH = 16;
    localparam int DATA_W      = 8;
    localparam int BURST_LEN   = 4;   // Reads per queue visit at most.
    localparam int CNT_W       = 16;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Derived values
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int QSEL_W    = $clog2(NUM_QUEUES);
    localparam int MEM_WORDS = NUM_QUEUES * QUEUE_DEPTH;
    localparam int ADDR_W    = $clog2(MEM_WORDS);
    localparam int BCNT_W    = $clog2(BURST_LEN + 1);

    // Slots of one queue sit NUM_QUEUES words apart.
    localparam logic [ADDR_W-1:0] ADDR_STEP = ADDR_W'(NUM_QUEUES);

    // Count value seen during the last read of a burst.
    localparam logic [BCNT_W-1:0] BURST_LAST = BCNT_W'(BURST_LEN - 1);

endpackage

`default_nettype wire

// File: hdl/mq_types_pkg.sv
`default_nettype none

package mq_types_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bundles passed between blocks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Incoming byte with its target queue.
    typedef struct packed {
        logic [mq_cfg_pkg::DATA_W-1:0] data;
        logic [mq_cfg_pkg::QSEL_W-1:0] qsel;
    } wr_req_t;

    // Read command from the drain engine.
    typedef struct packed {
        logic                          en;
        logic [mq_cfg_pkg::QSEL_W-1:0] qsel;
    } rd_req_t;

    // Word on the output port, tagged with its source queue.
    typedef struct packed {
        logic [mq_cfg_pkg::DATA_W-1:0] data;
        logic [mq_cfg_pkg::QSEL_W-1:0] qsel;
    } out_word_t;

endpackage

`default_nettype wire

// File: hdl/mq_store.sv
`default_nettype none
`timescale 1ns/10ps

module mq_store (
    input  logic                              clk,
    input  logic                              rst_n,
    input  mq_types_pkg::wr_req_t             in_req,
    input  logic                              in_valid,
    input  mq_types_pkg::rd_req_t             rd_req,
    output logic [mq_cfg_pkg::DATA_W-1:0]     rd_data,
    output logic [mq_cfg_pkg::NUM_QUEUES-1:0] empty,
    output logic [mq_cfg_pkg::NUM_QUEUES-1:0] full,
    output logic [mq_cfg_pkg::CNT_W-1:0]      drop_count
);

    // Shared storage, queue q owns addresses q, q+NUM_QUEUES, ...
    logic [mq_cfg_pkg::DATA_W-1:0] mem [mq_cfg_pkg::MEM_WORDS];

    logic [mq_cfg_pkg::ADDR_W-1:0] wr_ptr  [mq_cfg_pkg::NUM_QUEUES];
    logic [mq_cfg_pkg::ADDR_W-1:0] rd_ptr  [mq_cfg_pkg::NUM_QUEUES];
    logic [mq_cfg_pkg::ADDR_W-1:0] wr_succ [mq_cfg_pkg::NUM_QUEUES];
    logic [mq_cfg_pkg::ADDR_W-1:0] rd_succ [mq_cfg_pkg::NUM_QUEUES];

    logic [mq_cfg_pkg::NUM_QUEUES-1:0] wr_hit;
    logic [mq_cfg_pkg::NUM_QUEUES-1:0] rd_hit;
    logic [mq_cfg_pkg::NUM_QUEUES-1:0] wr_ok;
    logic [mq_cfg_pkg::NUM_QUEUES-1:0] rd_ok;
    logic                              drop;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Per-queue decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        for (int q = 0; q < mq_cfg_pkg::NUM_QUEUES; q++) begin
            wr_hit[q]  = in_valid && (in_req.qsel == q[mq_cfg_pkg::QSEL_W-1:0]);
            rd_hit[q]  = rd_req.en && (rd_req.qsel == q[mq_cfg_pkg::QSEL_W-1:0]);
            rd_ok[q]   = rd_hit[q] && !empty[q];
            wr_ok[q]   = wr_hit[q] && (!full[q] || rd_ok[q]); // Read frees a slot.
            wr_succ[q] = wr_ptr[q] + mq_cfg_pkg::ADDR_STEP;
            rd_succ[q] = rd_ptr[q] + mq_cfg_pkg::ADDR_STEP;
        end
    end

    assign drop    = |(wr_hit & ~wr_ok);
    assign rd_data = mem[rd_ptr[rd_req.qsel]];

    always_ff @(posedge clk) begin
        if (|wr_ok) begin
            mem[wr_ptr[in_req.qsel]] <= in_req.data;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pointers and flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int q = 0; q < mq_cfg_pkg::NUM_QUEUES; q++) begin
                wr_ptr[q] <= q[mq_cfg_pkg::ADDR_W-1:0];
                rd_ptr[q] <= q[mq_cfg_pkg::ADDR_W-1:0];
            end
            empty <= '1;
            full  <= '0;
        end else begin
            for (int q = 0; q < mq_cfg_pkg::NUM_QUEUES; q++) begin
                if (wr_ok[q]) begin
                    wr_ptr[q] <= wr_succ[q];
                end
                if (rd_ok[q]) begin
                    rd_ptr[q] <= rd_succ[q];
                end
                // Simultaneous read and write leave the flags alone.
                case ({rd_ok[q], wr_ok[q]})
                    2'b01: begin
                        empty[q] <= 1'b0;
                        if (wr_succ[q] == rd_ptr[q]) begin
                            full[q] <= 1'b1;
                        end
                    end
                    2'b10: begin
                        full[q] <= 1'b0;
                        if (rd_succ[q] == wr_ptr[q]) begin
                            empty[q] <= 1'b1;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Saturating drop counter.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drop_count <= '0;
        end else if (drop && (drop_count != '1)) begin
            drop_count <= drop_count + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_no_empty_read: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_req.en |-> !empty[rd_req.qsel]
    ) else $error("read issued to empty queue %0d", rd_req.qsel);

endmodule

`default_nettype wire

// File: hdl/drain_fsm.sv
`default_nettype none
`timescale 1ns/10ps

module drain_fsm (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [mq_cfg_pkg::NUM_QUEUES-1:0] empty,
    input  logic                              burst_done,
    output mq_types_pkg::rd_req_t             rd_req,
    output logic                              burst_start
);

    typedef enum logic [2:0] {
        IDLE   = 3'b001,
        SELECT = 3'b010,
        BURST  = 3'b100
    } state_t;

    state_t                        state;
    state_t                        state_nxt;
    logic [mq_cfg_pkg::QSEL_W-1:0] cur_q;   // Queue of the current or last burst.
    logic [mq_cfg_pkg::QSEL_W-1:0] next_q;
    logic                          any_ready;

    assign any_ready = ~&empty;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Round-robin pick
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Scan from the farthest offset down so the nearest hit wins.
    always_comb begin
        logic [mq_cfg_pkg::QSEL_W-1:0] idx;
        next_q = cur_q;
        for (int i = mq_cfg_pkg::NUM_QUEUES; i >= 1; i--) begin
            idx = cur_q + i[mq_cfg_pkg::QSEL_W-1:0];
            if (!empty[idx]) begin
                next_q = idx;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (any_ready) begin
                    state_nxt = SELECT;
                end
            end
            SELECT: begin
                state_nxt = any_ready ? BURST : IDLE;
            end
            BURST: begin
                if (empty[cur_q] || burst_done) begin
                    state_nxt = SELECT;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            cur_q <= '1;   // Queue 0 is served first.
        end else begin
            state <= state_nxt;
            if (burst_start) begin
                cur_q <= next_q;
            end
        end
    end

    assign burst_start = (state == SELECT) && any_ready;
    assign rd_req.en   = (state == BURST) && !empty[cur_q];
    assign rd_req.qsel = cur_q;

    a_state_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot(state)
    ) else $error("state register not one-hot");

endmodule

`default_nettype wire

// File: hdl/burst_timer.sv
`default_nettype none
`timescale 1ns/10ps

module burst_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic burst_start,
    input  logic rd_en,
    output logic burst_done
);

    logic [mq_cfg_pkg::BCNT_W-1:0] count;   // Reads so far in this burst.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (burst_start) begin
            count <= '0;
        end else if (rd_en) begin
            count <= count + 1'b1;
        end
    end

    // High during the last read allowed in the burst.
    assign burst_done = rd_en && (count == mq_cfg_pkg::BURST_LAST);

    a_count_limit: assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= mq_cfg_pkg::BURST_LEN
    ) else $error("burst count %0d above limit", count);

endmodule

`default_nettype wire

// File: hdl/egress_stage.sv
`default_nettype none
`timescale 1ns/10ps

module egress_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  mq_types_pkg::rd_req_t         rd_req,
    input  logic [mq_cfg_pkg::DATA_W-1:0] rd_data,
    output mq_types_pkg::out_word_t       out_word,
    output logic                          out_valid,
    output logic [mq_cfg_pkg::CNT_W-1:0]  deliver_count
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= rd_req.en;
        end
    end

    // Word and tag hold their value between strobes.
    always_ff @(posedge clk) begin
        if (rd_req.en) begin
            out_word.data <= rd_data;
            out_word.qsel <= rd_req.qsel;
        end
    end

    // Counts each word as it is launched to the output.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            deliver_count <= '0;
        end else if (rd_req.en && (deliver_count != '1)) begin
            deliver_count <= deliver_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mq_buffer_top.sv
`default_nettype none
`timescale 1ns/10ps

module mq_buffer_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  mq_types_pkg::wr_req_t             in_req,
    input  logic                              in_valid,
    output mq_types_pkg::out_word_t           out_word,
    output logic                              out_valid,
    output logic [mq_cfg_pkg::NUM_QUEUES-1:0] empty,
    output logic [mq_cfg_pkg::NUM_QUEUES-1:0] full,
    output logic [mq_cfg_pkg::CNT_W-1:0]      drop_count,
    output logic [mq_cfg_pkg::CNT_W-1:0]      deliver_count
);

    mq_types_pkg::rd_req_t         rd_req;
    logic [mq_cfg_pkg::DATA_W-1:0] rd_data;
    logic                          burst_start;
    logic                          burst_done;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage and drain path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    mq_store mq_store_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_req     (in_req),
        .in_valid   (in_valid),
        .rd_req     (rd_req),
        .rd_data    (rd_data),
        .empty      (empty),
        .full       (full),
        .drop_count (drop_count)
    );

    drain_fsm drain_fsm_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .empty       (empty),
        .burst_done  (burst_done),
        .rd_req      (rd_req),
        .burst_start (burst_start)
    );

    burst_timer burst_timer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .burst_start (burst_start),
        .rd_en       (rd_req.en),
        .burst_done  (burst_done)
    );

    egress_stage egress_stage_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd_req        (rd_req),
        .rd_data       (rd_data),
        .out_word      (out_word),
        .out_valid     (out_valid),
        .deliver_count (deliver_count)
    );

endmodule

`default_nettype wire

// File: tb/mq_buffer_tb.sv
`default_nettype none
`timescale 1ns/10ps

module mq_buffer_tb;

    localparam int PH1_WRITES   = 120;
    localparam int PH2_WRITES   = 320;
    localparam int PH3_CYCLES   = 240;
    localparam int STIM_CYCLES  = 3 + PH1_WRITES + PH2_WRITES + PH3_CYCLES;
    localparam int MAX_WRITES   = PH1_WRITES + PH2_WRITES + PH3_CYCLES;
    localparam int DRAIN_CYCLES = 2 * MAX_WRITES;   // One select cycle per word at worst.
    localparam int CYCLE_LIMIT  = 2 * STIM_CYCLES + DRAIN_CYCLES;

    logic                                clk;
    logic                                rst_n;
    mq_types_pkg::wr_req_t               in_req;
    logic                                in_valid;
    mq_types_pkg::out_word_t             out_word;
    logic                                out_valid;
    logic [mq_cfg_pkg::NUM_QUEUES-1:0]   empty;
    logic [mq_cfg_pkg::NUM_QUEUES-1:0]   full;
    logic [mq_cfg_pkg::CNT_W-1:0]        drop_count;
    logic [mq_cfg_pkg::CNT_W-1:0]        deliver_count;

    integer seed;
    int     cycles = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [mq_cfg_pkg::DATA_W-1:0]       ref_q [mq_cfg_pkg::NUM_QUEUES][$];
    logic                                pend_valid;   // Write waiting for its verdict.
    mq_types_pkg::wr_req_t               pend_req;
    logic [mq_cfg_pkg::NUM_QUEUES-1:0]   front_valid;
    logic [mq_cfg_pkg::NUM_QUEUES-1:0][mq_cfg_pkg::DATA_W-1:0] front_data;
    logic [mq_cfg_pkg::NUM_QUEUES-1:0]   exp_full;
    logic [mq_cfg_pkg::NUM_QUEUES-1:0]   exp_empty;
    logic [mq_cfg_pkg::CNT_W-1:0]        drops;
    logic [mq_cfg_pkg::CNT_W-1:0]        strobes;
    logic                                prev_valid;
    logic [mq_cfg_pkg::QSEL_W-1:0]       prev_tag;
    logic [mq_cfg_pkg::QSEL_W-1:0]       last_tag;     // Queue of the latest burst.
    logic [mq_cfg_pkg::QSEL_W-1:0]       rr_pick;
    int                                  run_len;
    int                                  accepted;

    mq_buffer_top mq_buffer_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_req        (in_req),
        .in_valid      (in_valid),
        .out_word      (out_word),
        .out_valid     (out_valid),
        .empty         (empty),
        .full          (full),
        .drop_count    (drop_count),
        .deliver_count (deliver_count)
    );

    always #20 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // First occupied queue after the last one served, wrapping back to it.
    function automatic logic [mq_cfg_pkg::QSEL_W-1:0] rr_next(
        input logic [mq_cfg_pkg::QSEL_W-1:0]     last,
        input logic [mq_cfg_pkg::NUM_QUEUES-1:0] busy
    );
        logic [mq_cfg_pkg::QSEL_W-1:0] cand;
        logic                          found;
        rr_next = last;
        found   = 1'b0;
        for (int i = 1; i <= mq_cfg_pkg::NUM_QUEUES; i++) begin
            cand = last + i[mq_cfg_pkg::QSEL_W-1:0];
            if (!found && busy[cand]) begin
                rr_next = cand;
                found   = 1'b1;
            end
        end
    endfunction

    function automatic int held_words();
        int total;
        total = 0;
        for (int i = 0; i < mq_cfg_pkg::NUM_QUEUES; i++) begin
            total += ref_q[i].size();
        end
        return total;
    endfunction

    task automatic drive_cycle(
        input logic                          valid,
        input logic [mq_cfg_pkg::QSEL_W-1:0] q,
        input logic [mq_cfg_pkg::DATA_W-1:0] d
    );
        in_valid     = valid;
        in_req.qsel  = q;
        in_req.data  = d;
        @(negedge clk);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Model update, one step per clock
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        logic [mq_cfg_pkg::NUM_QUEUES-1:0] busy;
        logic                              rd_same;
        if (!rst_n) begin
            for (int i = 0; i < mq_cfg_pkg::NUM_QUEUES; i++) begin
                ref_q[i].delete();
            end
            pend_valid  <= 1'b0;
            pend_req    <= '0;
            prev_valid  <= 1'b0;
            prev_tag    <= '0;
            last_tag    <= '1;
            rr_pick     <= '0;
            run_len     <= 0;
            drops       <= '0;
            strobes     <= '0;
            accepted     = 0;
            front_valid <= '0;
            front_data  <= '0;
            exp_full    <= '0;
            exp_empty   <= '1;
        end else begin
            // Occupancy the scheduler saw one cycle back.
            for (int i = 0; i < mq_cfg_pkg::NUM_QUEUES; i++) begin
                busy[i] = (ref_q[i].size() != 0);
            end
            rr_pick <= rr_next(last_tag, busy);
            // A full queue still takes a write when a read hits it in the same cycle.
            if (pend_valid) begin
                rd_same = out_valid && (out_word.qsel == pend_req.qsel);
                if ((ref_q[pend_req.qsel].size() == mq_cfg_pkg::QUEUE_DEPTH) && !rd_same) begin
                    drops <= drops + 1'b1;
                end else begin
                    ref_q[pend_req.qsel].push_back(pend_req.data);
                    accepted++;
                end
            end
            if (out_valid) begin
                if (ref_q[out_word.qsel].size() != 0) begin
                    void'(ref_q[out_word.qsel].pop_front());
                end
                strobes  <= strobes + 1'b1;
                last_tag <= out_word.qsel;
                run_len  <= (prev_valid && (out_word.qsel == prev_tag)) ? run_len + 1 : 1;
            end else begin
                run_len <= 0;
            end
            prev_valid <= out_valid;
            prev_tag   <= out_word.qsel;
            pend_valid <= in_valid;
            pend_req   <= in_req;
            for (int i = 0; i < mq_cfg_pkg::NUM_QUEUES; i++) begin
                front_valid[i] <= (ref_q[i].size() != 0);
                front_data[i]  <= (ref_q[i].size() != 0) ? ref_q[i][0] : '0;
                exp_full[i]    <= (ref_q[i].size() == mq_cfg_pkg::QUEUE_DEPTH);
                exp_empty[i]   <= (ref_q[i].size() == 0);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_word_order: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> front_valid[out_word.qsel] && (out_word.data == front_data[out_word.qsel])
    ) else fail_now($sformatf("queue %0d delivered %02h, expected %02h", out_word.qsel,
                              out_word.data, front_data[out_word.qsel]));

    a_flags: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(full) == exp_full) && ($past(empty) == exp_empty)
    ) else fail_now($sformatf("flags full %b empty %b, expected full %b empty %b",
                              $past(full), $past(empty), exp_full, exp_empty));

    a_drops: assert property (@(posedge clk) disable iff (!rst_n)
        $past(drop_count) == drops
    ) else fail_now($sformatf("drop_count %0d, expected %0d", $past(drop_count), drops));

    a_delivered: assert property (@(posedge clk) disable iff (!rst_n)
        deliver_count == strobes + {{(mq_cfg_pkg::CNT_W-1){1'b0}}, out_valid}
    ) else fail_now($sformatf("deliver_count %0d, strobes seen %0d", deliver_count, strobes));

    a_burst_len: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && prev_valid && (out_word.qsel == prev_tag)) |->
            (run_len < mq_cfg_pkg::BURST_LEN)
    ) else fail_now($sformatf("burst on queue %0d longer than limit", out_word.qsel));

    a_rr_order: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !prev_valid) |-> (out_word.qsel == rr_pick)
    ) else fail_now($sformatf("burst served queue %0d, expected %0d", out_word.qsel, rr_pick));

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the test did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [31:0] rnd;
        seed     = 32'h595cce1b;
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_req   = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // Queue 0 alone, faster than the drain can follow.
        for (int i = 0; i < PH1_WRITES; i++) begin
            rnd = $random(seed);
            drive_cycle(1'b1, '0, rnd[mq_cfg_pkg::DATA_W-1:0]);
        end
        // All queues in turn while the drain runs.
        for (int i = 0; i < PH2_WRITES; i++) begin
            rnd = $random(seed);
            drive_cycle(1'b1, i[mq_cfg_pkg::QSEL_W-1:0], rnd[mq_cfg_pkg::DATA_W-1:0]);
        end
        for (int i = 0; i < PH3_CYCLES; i++) begin
            rnd = $random(seed);
            drive_cycle(rnd[9:8] != 2'b00, rnd[mq_cfg_pkg::QSEL_W+15:16],
                        rnd[mq_cfg_pkg::DATA_W-1:0]);
        end

        in_valid = 1'b0;
        while (empty != '1) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);   // Let the last strobe retire.

        a_drained: assert ((empty == '1) && (full == '0) && (held_words() == 0))
            else fail_now("queues still hold words after the idle phase");
        a_balance: assert (int'(deliver_count) + held_words() == accepted)
            else fail_now($sformatf("delivered %0d plus held %0d, accepted %0d",
                                    deliver_count, held_words(), accepted));

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
hdl/mq_cfg_pkg.sv
hdl/mq_types_pkg.sv
hdl/mq_store.sv
hdl/drain_fsm.sv
hdl/burst_timer.sv
hdl/egress_stage.sv
hdl/mq_buffer_top.sv
tb/mq_buffer_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the multi-queue buffer testbench with Verilator.
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal --top-module mq_buffer_tb -f files.f

# The log decides the result, so the run itself may end with a non-zero status.
./obj_dir/Vmq_buffer_tb 2>&1 | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "Simulation result: pass"
    exit 0
else
    echo "Simulation result: fail, see sim.log"
    exit 1
fi
